// File: frontend_pkg.sv
package frontend_pkg;

    localparam int inst_w = 32;
    localparam int addr_w = 32;

    // opcode field
    localparam int op_msb = 31;
    localparam int op_lsb = 26;
    localparam int op_w   = op_msb - op_lsb + 1;

    // register fields
    localparam int reg_w  = 5;
    localparam int rs_msb = 25;
    localparam int rs_lsb = 21;
    localparam int rt_msb = 20;
    localparam int rt_lsb = 16;
    localparam int rd_msb = 15;
    localparam int rd_lsb = 11;

    localparam logic [op_w-1:0] opc_nop    = 6'b000000;
    localparam logic [op_w-1:0] opc_branch = 6'b000100;
    localparam logic [op_w-1:0] opc_load   = 6'b100011;
    localparam logic [op_w-1:0] opc_store  = 6'b101011;

    // everything not listed above decodes as alu
    typedef enum logic [2:0] {op_alu, op_load, op_store, op_branch, op_nop} op_kind;

endpackage

// File: issue_pkg.sv
package issue_pkg;

    // branch / delay slot tracking
    // st_slot_wait: branch went alone, next master is its delay slot
    // st_branch_pending: branch and delay slot went as a pair
    typedef enum logic [1:0] {
        st_idle,
        st_branch_pending,
        st_slot_wait
    } ds_state;

    localparam int cnt_w_default = 32; // statistics counters

endpackage

// File: if_id.sv
module if_id (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            f_ok1,
    input  logic                            f_ok2,
    input  logic [frontend_pkg::addr_w-1:0] f_addr1,
    input  logic [frontend_pkg::addr_w-1:0] f_addr2,
    input  logic [frontend_pkg::inst_w-1:0] f_data1,
    input  logic [frontend_pkg::inst_w-1:0] f_data2,
    input  logic                            issue1,
    input  logic                            issue2,
    input  logic                            keep_slot,
    input  logic                            flush,
    output logic                            d_ok1,
    output logic                            d_ok2,
    output logic [frontend_pkg::addr_w-1:0] d_addr1,
    output logic [frontend_pkg::addr_w-1:0] d_addr2,
    output logic [frontend_pkg::inst_w-1:0] d_data1,
    output logic [frontend_pkg::inst_w-1:0] d_data2,
    output logic [1:0]                      fetch_take,
    output logic                            occupy
);

    // held delay slot instruction
    logic                            hold;
    logic [frontend_pkg::inst_w-1:0] hold_data;
    logic [frontend_pkg::addr_w-1:0] hold_addr;

    // slave that missed issue
    logic [frontend_pkg::inst_w-1:0] occ_data;
    logic [frontend_pkg::addr_w-1:0] occ_addr;

    logic hold_capture;
    logic occ_capture;

    always_comb begin
        d_ok1   = 1'b0;
        d_ok2   = 1'b0;
        d_data1 = '0;
        d_data2 = '0;
        d_addr1 = '0;
        d_addr2 = '0;
        if (hold) begin // delay slot goes alone
            d_ok1   = 1'b1;
            d_data1 = hold_data;
            d_addr1 = hold_addr;
        end else if (occupy) begin
            d_ok1   = 1'b1;
            d_data1 = occ_data;
            d_addr1 = occ_addr;
            d_ok2   = f_ok1;
            d_data2 = f_data1;
            d_addr2 = f_addr1;
        end else if (keep_slot) begin
            d_ok1   = f_ok1;
            d_data1 = f_data1;
            d_addr1 = f_addr1;
        end else if (!flush) begin
            d_ok1   = f_ok1;
            d_data1 = f_data1;
            d_addr1 = f_addr1;
            d_ok2   = f_ok1 && f_ok2; // slot 2 only behind slot 1
            d_data2 = f_data2;
            d_addr2 = f_addr2;
        end
    end

    // master stuck when the redirect arrives
    assign hold_capture = keep_slot && !issue1 && !hold && d_ok1;
    // wrong-path slaves are dropped, not captured
    assign occ_capture  = issue1 && d_ok2 && !issue2 && !keep_slot && !flush;

    always_comb begin
        if (hold)
            fetch_take = 2'd0;
        else if (flush && !issue1)
            fetch_take = 2'd0;
        else if (occupy)
            fetch_take = issue1 ? 2'd1 : 2'd0; // only fetch slot 1 is on offer
        else if (issue1)
            fetch_take = d_ok2 ? 2'd2 : 2'd1; // slave issued or captured
        else
            fetch_take = 2'd0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupy <= 1'b0;
            hold   <= 1'b0;
        end else begin
            if (hold_capture)
                occupy <= 1'b0; // occupied master moves to the hold
            else if (issue1 || flush)
                occupy <= occ_capture;

            if (hold_capture)
                hold <= 1'b1;
            else if (issue1)
                hold <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_capture) begin
            hold_data <= d_data1;
            hold_addr <= d_addr1;
        end
        if (occ_capture) begin
            occ_data <= d_data2;
            occ_addr <= d_addr2;
        end
    end

    a_hold_occupy_excl: assert property (@(posedge clk) disable iff (rst)
        !(occupy && hold));

    a_slot2_behind_slot1: assert property (@(posedge clk) disable iff (rst)
        $rose(d_ok2) |-> d_ok1);

endmodule

// File: issue_ctrl.sv
module issue_ctrl (
    input  logic                            d_ok1,
    input  logic                            d_ok2,
    input  logic [frontend_pkg::inst_w-1:0] d_data1,
    input  logic [frontend_pkg::inst_w-1:0] d_data2,
    input  logic                            stall,
    input  logic                            in_delayslot,
    output logic                            issue1,
    output logic                            issue2,
    output logic                            branch1
);

    frontend_pkg::op_kind kind1;
    frontend_pkg::op_kind kind2;

    logic [frontend_pkg::reg_w-1:0] dest1;
    logic [frontend_pkg::reg_w-1:0] rs2;
    logic [frontend_pkg::reg_w-1:0] rt2;
    logic                           has_dest1;
    logic                           raw;
    logic                           mem_pair;

    function automatic frontend_pkg::op_kind decode(
        input logic [frontend_pkg::inst_w-1:0] inst
    );
        logic [frontend_pkg::op_w-1:0] op;
        op = inst[frontend_pkg::op_msb:frontend_pkg::op_lsb];
        case (op)
            frontend_pkg::opc_nop:    decode = frontend_pkg::op_nop;
            frontend_pkg::opc_branch: decode = frontend_pkg::op_branch;
            frontend_pkg::opc_load:   decode = frontend_pkg::op_load;
            frontend_pkg::opc_store:  decode = frontend_pkg::op_store;
            default:                  decode = frontend_pkg::op_alu;
        endcase
    endfunction

    assign kind1 = decode(d_data1);
    assign kind2 = decode(d_data2);
    assign rs2   = d_data2[frontend_pkg::rs_msb:frontend_pkg::rs_lsb];
    assign rt2   = d_data2[frontend_pkg::rt_msb:frontend_pkg::rt_lsb];

    // master destination register
    always_comb begin
        has_dest1 = 1'b0;
        dest1     = d_data1[frontend_pkg::rd_msb:frontend_pkg::rd_lsb];
        case (kind1)
            frontend_pkg::op_alu:  has_dest1 = 1'b1;
            frontend_pkg::op_load: begin
                has_dest1 = 1'b1;
                dest1     = d_data1[frontend_pkg::rt_msb:frontend_pkg::rt_lsb];
            end
            default: has_dest1 = 1'b0;
        endcase
    end

    assign raw      = has_dest1 && (rs2 == dest1 || rt2 == dest1);
    assign mem_pair = (kind1 == frontend_pkg::op_load || kind1 == frontend_pkg::op_store)
                   && (kind2 == frontend_pkg::op_load || kind2 == frontend_pkg::op_store);

    assign issue1  = d_ok1 && !stall;
    assign issue2  = issue1 && d_ok2 && kind2 != frontend_pkg::op_branch && !raw && !mem_pair;
    // a branch sitting in a delay slot is not tracked as one
    assign branch1 = d_ok1 && kind1 == frontend_pkg::op_branch && !in_delayslot;

endmodule

// File: delayslot_fsm.sv
module delayslot_fsm (
    input  logic clk,
    input  logic rst,
    input  logic issue1,
    input  logic issue2,
    input  logic branch1,
    input  logic redirect,
    output logic keep_slot,
    output logic flush,
    output logic in_delayslot
);

    issue_pkg::ds_state state;
    issue_pkg::ds_state state_next;

    always_comb begin
        state_next = state;
        case (state)
            issue_pkg::st_idle,
            issue_pkg::st_branch_pending: begin
                if (redirect)
                    state_next = issue_pkg::st_idle; // flushed
                else if (issue1 && branch1)
                    state_next = issue2 ? issue_pkg::st_branch_pending
                                        : issue_pkg::st_slot_wait;
                else if (issue1)
                    state_next = issue_pkg::st_idle;
            end
            issue_pkg::st_slot_wait: begin
                if (issue1) // delay slot is out
                    state_next = issue_pkg::st_idle;
            end
            default: state_next = issue_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= issue_pkg::st_idle;
        else
            state <= state_next;
    end

    assign in_delayslot = state == issue_pkg::st_slot_wait;
    assign keep_slot    = redirect && in_delayslot;  // delay slot still owed
    assign flush        = redirect && !in_delayslot;

    // only a lone branch opens the delay slot window
    a_slot_after_branch: assert property (@(posedge clk) disable iff (rst)
        $rose(in_delayslot) |-> $past(issue1 && branch1 && !issue2));

endmodule

// File: issue_counter.sv
module issue_counter #(
    parameter int COUNT_WIDTH = issue_pkg::cnt_w_default
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue1,
    input  logic                   issue2,
    input  logic                   in_delayslot,
    output logic [COUNT_WIDTH-1:0] master_count,
    output logic [COUNT_WIDTH-1:0] slave_count,
    output logic [COUNT_WIDTH-1:0] dual_count
);

    always_ff @(posedge clk) begin
        if (rst) begin
            master_count <= '0;
            slave_count  <= '0;
            dual_count   <= '0;
        end else begin
            if (issue1)
                master_count <= master_count + 1'b1; // wraps
            if (issue2)
                slave_count <= slave_count + 1'b1;
            if (issue1 && issue2)
                dual_count <= dual_count + 1'b1;
        end
    end

    // a delay slot is counted once, window closes on its issue
    a_slot_counted_once: assert property (@(posedge clk) disable iff (rst)
        (in_delayslot && issue1) |=> !in_delayslot);

endmodule

// File: frontend_top.sv
module frontend_top #(
    parameter int COUNT_WIDTH = issue_pkg::cnt_w_default
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            f_ok1,
    input  logic                            f_ok2,
    input  logic [frontend_pkg::addr_w-1:0] f_addr1,
    input  logic [frontend_pkg::addr_w-1:0] f_addr2,
    input  logic [frontend_pkg::inst_w-1:0] f_data1,
    input  logic [frontend_pkg::inst_w-1:0] f_data2,
    input  logic                            stall,
    input  logic                            redirect,
    output logic                            d_ok1,
    output logic                            d_ok2,
    output logic [frontend_pkg::addr_w-1:0] d_addr1,
    output logic [frontend_pkg::addr_w-1:0] d_addr2,
    output logic [frontend_pkg::inst_w-1:0] d_data1,
    output logic [frontend_pkg::inst_w-1:0] d_data2,
    output logic                            issue1,
    output logic                            issue2,
    output logic                            in_delayslot,
    output logic [1:0]                      fetch_take,
    output logic [COUNT_WIDTH-1:0]          master_count,
    output logic [COUNT_WIDTH-1:0]          slave_count,
    output logic [COUNT_WIDTH-1:0]          dual_count
);

    logic branch1;
    logic keep_slot;
    logic flush;

    if_id u_if_id (
        .clk        (clk),
        .rst        (rst),
        .f_ok1      (f_ok1),
        .f_ok2      (f_ok2),
        .f_addr1    (f_addr1),
        .f_addr2    (f_addr2),
        .f_data1    (f_data1),
        .f_data2    (f_data2),
        .issue1     (issue1),
        .issue2     (issue2),
        .keep_slot  (keep_slot),
        .flush      (flush),
        .d_ok1      (d_ok1),
        .d_ok2      (d_ok2),
        .d_addr1    (d_addr1),
        .d_addr2    (d_addr2),
        .d_data1    (d_data1),
        .d_data2    (d_data2),
        .fetch_take (fetch_take),
        .occupy     ()              // internal to the pair register
    );

    issue_ctrl u_issue_ctrl (
        .d_ok1        (d_ok1),
        .d_ok2        (d_ok2),
        .d_data1      (d_data1),
        .d_data2      (d_data2),
        .stall        (stall),
        .in_delayslot (in_delayslot),
        .issue1       (issue1),
        .issue2       (issue2),
        .branch1      (branch1)
    );

    delayslot_fsm u_delayslot_fsm (
        .clk          (clk),
        .rst          (rst),
        .issue1       (issue1),
        .issue2       (issue2),
        .branch1      (branch1),
        .redirect     (redirect),
        .keep_slot    (keep_slot),
        .flush        (flush),
        .in_delayslot (in_delayslot)
    );

    issue_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_issue_counter (
        .clk          (clk),
        .rst          (rst),
        .issue1       (issue1),
        .issue2       (issue2),
        .in_delayslot (in_delayslot),
        .master_count (master_count),
        .slave_count  (slave_count),
        .dual_count   (dual_count)
    );

endmodule

// File: tb_frontend.sv
module tb_frontend;

    localparam int count_w   = 16;
    localparam int max_lines = 64;

    logic                            clk;
    logic                            rst;
    logic                            f_ok1;
    logic                            f_ok2;
    logic [frontend_pkg::addr_w-1:0] f_addr1;
    logic [frontend_pkg::addr_w-1:0] f_addr2;
    logic [frontend_pkg::inst_w-1:0] f_data1;
    logic [frontend_pkg::inst_w-1:0] f_data2;
    logic                            stall;
    logic                            redirect;
    logic                            d_ok1;
    logic                            d_ok2;
    logic [frontend_pkg::addr_w-1:0] d_addr1;
    logic [frontend_pkg::addr_w-1:0] d_addr2;
    logic [frontend_pkg::inst_w-1:0] d_data1;
    logic [frontend_pkg::inst_w-1:0] d_data2;
    logic                            issue1;
    logic                            issue2;
    logic                            in_delayslot;
    logic [1:0]                      fetch_take;
    logic [count_w-1:0]              master_count;
    logic [count_w-1:0]              slave_count;
    logic [count_w-1:0]              dual_count;

    // columns 0..7 stimulus, 8..14 expected
    string       names [max_lines];
    logic [31:0] cols  [max_lines][15];
    int          n_lines;

    logic [31:0] data_at [logic [31:0]]; // instruction offered at each address
    logic        exp_ds;

    string cur_test;
    int    tests;
    int    checks;
    int    errors;
    int    test_checks;
    int    test_errors;
    int    tot_master;
    int    tot_slave;
    int    tot_dual;
    int    cycles;
    int    limit;

    frontend_top #(
        .COUNT_WIDTH (count_w)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .f_ok1        (f_ok1),
        .f_ok2        (f_ok2),
        .f_addr1      (f_addr1),
        .f_addr2      (f_addr2),
        .f_data1      (f_data1),
        .f_data2      (f_data2),
        .stall        (stall),
        .redirect     (redirect),
        .d_ok1        (d_ok1),
        .d_ok2        (d_ok2),
        .d_addr1      (d_addr1),
        .d_addr2      (d_addr2),
        .d_data1      (d_data1),
        .d_data2      (d_data2),
        .issue1       (issue1),
        .issue2       (issue2),
        .in_delayslot (in_delayslot),
        .fetch_take   (fetch_take),
        .master_count (master_count),
        .slave_count  (slave_count),
        .dual_count   (dual_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: trace did not finish within %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic drive_idle();
        f_ok1    = 1'b0;
        f_ok2    = 1'b0;
        f_addr1  = '0;
        f_addr2  = '0;
        f_data1  = '0;
        f_data2  = '0;
        stall    = 1'b0;
        redirect = 1'b0;
    endtask

    task automatic read_trace();
        int          fd;
        int          got;
        string       line;
        string       name;
        logic [31:0] v [15];
        n_lines = 0;
        fd = $fopen("frontend_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open frontend_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line[0] == "#")
                continue; // blank or comment
            got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                          v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (got != 16) begin
                $display("trace line %0d is malformed", n_lines + 1);
                errors++;
            end else if (n_lines == max_lines) begin
                $display("trace has more than %0d lines", max_lines);
                errors++;
                break;
            end else begin
                names[n_lines] = name;
                cols[n_lines]  = v;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input int i);
        f_ok1    = cols[i][0][0];
        f_ok2    = cols[i][1][0];
        f_addr1  = cols[i][2];
        f_addr2  = cols[i][3];
        f_data1  = cols[i][4];
        f_data2  = cols[i][5];
        stall    = cols[i][6][0];
        redirect = cols[i][7][0];
        if (cols[i][0][0])
            data_at[cols[i][2]] = cols[i][4];
        if (cols[i][1][0])
            data_at[cols[i][3]] = cols[i][5];
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic check_line(input int i);
        if (names[i] != cur_test) begin
            if (cur_test != "")
                report_test();
            cur_test = names[i];
        end
        check_value("d_ok1", cols[i][8], 32'(d_ok1));
        check_value("d_ok2", cols[i][9], 32'(d_ok2));
        if (cols[i][8][0]) begin // address only means something in a live slot
            check_value("d_addr1", cols[i][10], d_addr1);
            check_value("d_data1", data_at[cols[i][10]], d_data1);
        end
        if (cols[i][9][0]) begin
            check_value("d_addr2", cols[i][11], d_addr2);
            check_value("d_data2", data_at[cols[i][11]], d_data2);
        end
        check_value("issue1", cols[i][12], 32'(issue1));
        check_value("issue2", cols[i][13], 32'(issue2));
        check_value("fetch_take", cols[i][14], 32'(fetch_take));
        check_value("in_delayslot", 32'(exp_ds), 32'(in_delayslot));
        if (cols[i][12][0])
            tot_master++;
        if (cols[i][13][0])
            tot_slave++;
        if (cols[i][12][0] && cols[i][13][0])
            tot_dual++;
        // window opens on a lone branch, closes on the next master issue
        if (exp_ds)
            exp_ds = !cols[i][12][0];
        else if (cols[i][12][0] && !cols[i][13][0] && !cols[i][7][0])
            exp_ds = data_at[cols[i][10]][31:26] == frontend_pkg::opc_branch;
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        rst         = 1'b1;
        cur_test    = "";
        tests       = 0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        tot_master  = 0;
        tot_slave   = 0;
        tot_dual    = 0;
        cycles      = 0;
        limit       = 20;
        exp_ds      = 1'b0;
        drive_idle();
        read_trace();
        limit = 2 * n_lines + 20;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < n_lines; i++) begin
            @(negedge clk);
            apply_line(i);
            #4; // just ahead of the rising edge
            check_line(i);
        end

        @(negedge clk);
        drive_idle();
        if (cur_test != "")
            report_test();

        // counters have taken the last trace line by now
        cur_test = "statistics";
        check_value("master_count", 32'(tot_master % (1 << count_w)), 32'(master_count));
        check_value("slave_count", 32'(tot_slave % (1 << count_w)), 32'(slave_count));
        check_value("dual_count", 32'(tot_dual % (1 << count_w)), 32'(dual_count));
        report_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: frontend_trace.txt
# test f_ok1 f_ok2 f_addr1 f_addr2 f_data1 f_data2 stall redirect, then expected
# d_ok1 d_ok2 d_addr1 d_addr2 issue1 issue2 fetch_take; all hex, address 0 in an empty slot
# dual: op_alu pairs with no shared registers
dual      1 1 00000100 00000104 20225000 20645800 0 0 1 1 00000100 00000104 1 1 2
dual      1 1 00000108 0000010c 20a66000 20e86800 0 0 1 1 00000108 0000010c 1 1 2
# hazard: slave rs reads master rd 14, slave kept in occupy
hazard    1 1 00000110 00000114 20227000 21c37800 0 0 1 1 00000110 00000114 1 0 2
hazard    1 1 00000118 0000011c 20228000 20648800 0 0 1 1 00000114 00000118 1 1 1
# stall: occupied slave survives two stalled cycles
stall     1 1 0000011c 00000120 20648800 2225a000 0 0 1 1 0000011c 00000120 1 0 2
stall     1 1 00000124 00000128 20225000 10220004 1 0 1 1 00000120 00000124 0 0 0
stall     1 1 00000124 00000128 20225000 10220004 1 0 1 1 00000120 00000124 0 0 0
stall     1 1 00000124 00000128 20225000 10220004 0 0 1 1 00000120 00000124 1 1 1
# delayslot: op_branch alone, redirect while its op_alu slot is stalled
delayslot 1 0 00000128 0000012c 10220004 20226800 0 0 1 0 00000128 00000000 1 0 1
delayslot 1 1 0000012c 00000130 20226800 20645000 1 1 1 0 0000012c 00000000 0 0 0
delayslot 1 1 00000200 00000204 20645000 20a65800 0 0 1 0 0000012c 00000000 1 0 0
delayslot 1 1 00000200 00000204 20645000 20a65800 0 0 1 1 00000200 00000204 1 1 2
# flush: op_branch with its slot as a pair, then redirect
flush     1 1 00000208 0000020c 10220004 20646000 0 0 1 1 00000208 0000020c 1 1 2
flush     1 1 00000210 00000214 20a66000 20e86800 0 1 0 0 00000000 00000000 0 0 0
flush     1 1 00000300 00000304 20225000 20645800 0 0 1 1 00000300 00000304 1 1 2
# mempair: op_load with op_store splits, store goes next with an op_alu
mempair   1 1 00000308 0000030c 8c2a0000 ac430000 0 0 1 1 00000308 0000030c 1 0 2
mempair   1 1 00000310 00000314 20a66000 20e86800 0 0 1 1 0000030c 00000310 1 1 1
mempair   0 0 00000314 00000318 20e86800 00000000 0 0 0 0 00000000 00000000 0 0 0

// File: filelist.f
frontend_pkg.sv
issue_pkg.sv
if_id.sv
issue_ctrl.sv
delayslot_fsm.sv
issue_counter.sv
frontend_top.sv
tb_frontend.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --top-module tb_frontend -f filelist.f -o tb_frontend
	./obj_dir/tb_frontend > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
